// File: i3c_target_pkg.sv
// Widths are fixed by the I3C SDR protocol and are not meant to be changed by a user
`default_nettype none

package i3c_target_pkg;

  // Protocol widths
  localparam int unsigned AddrWidth  = 7;
  localparam int unsigned ByteWidth  = 8;

  // RX descriptor layout
  localparam int unsigned DescWidth       = 32;
  localparam int unsigned CountWidth      = 16;
  localparam int unsigned DescParityBit   = 31;
  localparam int unsigned DescOverflowBit = 30;

  // Flops in each input synchronizer
  localparam int unsigned SyncStages = 2;

  typedef enum logic [2:0] {
    Idle,
    AddrBits,
    AddrAck,
    DataBits,
    TBit,
    Ignore
  } rx_state_e;

endpackage

`default_nettype wire

// File: bus_event_if.sv
// All events are one-cycle pulses in the clk_i domain and lag the bus pins by three cycles
`timescale 1ns/100ps
`default_nettype none

interface bus_event_if ();

  logic scl_posedge;
  logic scl_negedge;
  // Also set for a repeated START
  logic start_det;
  logic stop_det;
  logic sda;

  modport monitor (output scl_posedge, output scl_negedge, output start_det,
                   output stop_det, output sda);

  modport fsm (input scl_posedge, input scl_negedge, input start_det,
               input stop_det, input sda);

endinterface

`default_nettype wire

// File: rx_byte_if.sv
// No ready signal exists here because the bus cannot be stalled by the target
`timescale 1ns/100ps
`default_nettype none

interface rx_byte_if
  import i3c_target_pkg::*;
();

  logic                 byte_valid;
  logic [ByteWidth-1:0] byte_data;
  logic                 parity_err;
  logic                 xfer_end;

  modport fsm (output byte_valid, output byte_data, output parity_err, output xfer_end);

  modport writer (input byte_valid, input byte_data, input parity_err, input xfer_end);

endinterface

`default_nettype wire

// File: bus_monitor.sv
// Assumes clk_i is fast enough that every SCL and SDA level lasts several clock cycles
`timescale 1ns/100ps
`default_nettype none

module bus_monitor
  import i3c_target_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         scl_i,
  input  logic         sda_i,
  bus_event_if.monitor bus_o
);

  logic [SyncStages-1:0] scl_sync_q;
  logic [SyncStages-1:0] sda_sync_q;
  logic                  scl_s;
  logic                  sda_s;
  logic                  scl_prev_q;
  logic                  sda_prev_q;

  assign scl_s = scl_sync_q[SyncStages-1];
  assign sda_s = sda_sync_q[SyncStages-1];

  // Idle bus is high on both lines
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= '1;
      sda_sync_q <= '1;
      scl_prev_q <= 1'b1;
      sda_prev_q <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[SyncStages-2:0], scl_i};
      sda_sync_q <= {sda_sync_q[SyncStages-2:0], sda_i};
      scl_prev_q <= scl_s;
      sda_prev_q <= sda_s;
    end
  end

  // Edge register
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_o.scl_posedge <= 1'b0;
      bus_o.scl_negedge <= 1'b0;
      bus_o.start_det   <= 1'b0;
      bus_o.stop_det    <= 1'b0;
    end else begin
      bus_o.scl_posedge <= scl_s & ~scl_prev_q;
      bus_o.scl_negedge <= ~scl_s & scl_prev_q;
      // SDA may only change while SCL is high for START and STOP
      bus_o.start_det   <= scl_s & scl_prev_q & sda_prev_q & ~sda_s;
      bus_o.stop_det    <= scl_s & scl_prev_q & ~sda_prev_q & sda_s;
    end
  end

  // Level aligned with the event pulses
  assign bus_o.sda = sda_prev_q;

endmodule

`default_nettype wire

// File: target_rx_fsm.sv
// Acknowledges only SDR private writes to the static address; reads and broadcast are ignored
`timescale 1ns/100ps
`default_nettype none

module target_rx_fsm
  import i3c_target_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 target_enable_i,
  input  logic [AddrWidth-1:0] target_addr_i,
  bus_event_if.fsm             bus_i,
  output logic                 sda_o,
  rx_byte_if.fsm               rx_o,
  output logic                 parity_err_o
);

  rx_state_e                    state_q;
  logic [$clog2(ByteWidth)-1:0] bit_cnt_q;
  logic [ByteWidth-1:0]         shift_q;
  logic [ByteWidth-1:0]         shift_next;
  logic                         acked_q;
  logic                         addr_match;
  logic                         parity_bad_q;

  assign shift_next = {shift_q[ByteWidth-2:0], bus_i.sda};

  // Header is {addr, RnW}, only writes are taken
  assign addr_match = target_enable_i && !shift_next[0] &&
                      (shift_next[ByteWidth-1:1] == target_addr_i);

  always_ff @(posedge clk_i) begin
    if (bus_i.scl_posedge && (state_q == AddrBits || state_q == DataBits)) begin
      shift_q <= shift_next;
    end
    // Byte plus T bit must have odd parity
    if (bus_i.scl_posedge && state_q == TBit) begin
      parity_bad_q <= ~^{shift_q, bus_i.sda};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q         <= Idle;
      bit_cnt_q       <= '0;
      acked_q         <= 1'b0;
      sda_o           <= 1'b1;
      rx_o.byte_valid <= 1'b0;
      rx_o.xfer_end   <= 1'b0;
    end else begin
      rx_o.byte_valid <= 1'b0;
      rx_o.xfer_end   <= 1'b0;
      if (bus_i.start_det || bus_i.stop_det) begin
        // Close an acknowledged write on either condition
        rx_o.xfer_end <= acked_q;
        acked_q       <= 1'b0;
        sda_o         <= 1'b1;
        bit_cnt_q     <= '0;
        state_q       <= bus_i.start_det ? AddrBits : Idle;
      end else begin
        unique case (state_q)
          AddrBits: begin
            if (bus_i.scl_posedge) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (&bit_cnt_q) begin
                state_q <= addr_match ? AddrAck : Ignore;
              end
            end
          end
          AddrAck: begin
            // Hold SDA low for one full SCL period, negedge to negedge
            if (bus_i.scl_negedge) begin
              if (sda_o) begin
                sda_o   <= 1'b0;
                acked_q <= 1'b1;
              end else begin
                sda_o     <= 1'b1;
                bit_cnt_q <= '0;
                state_q   <= DataBits;
              end
            end
          end
          DataBits: begin
            if (bus_i.scl_posedge) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              if (&bit_cnt_q) begin
                state_q <= TBit;
              end
            end
          end
          TBit: begin
            if (bus_i.scl_posedge) begin
              rx_o.byte_valid <= 1'b1;
              bit_cnt_q       <= '0;
              state_q         <= DataBits;
            end
          end
          // Idle and Ignore wait for START or STOP
          default: ;
        endcase
      end
    end
  end

  // Byte stays in the shift register until the next data bit
  assign rx_o.byte_data  = shift_q;
  assign rx_o.parity_err = parity_bad_q;
  assign parity_err_o    = rx_o.byte_valid & parity_bad_q;

endmodule

`default_nettype wire

// File: rx_descriptor_writer.sv
// Bytes that arrive while the RX queue is not ready are dropped and flagged in the descriptor
`timescale 1ns/100ps
`default_nettype none

module rx_descriptor_writer
  import i3c_target_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  rx_byte_if.writer            rx_i,
  input  logic                 rx_queue_wready_i,
  output logic                 rx_queue_wvalid_o,
  output logic [ByteWidth-1:0] rx_queue_wdata_o,
  output logic                 rx_desc_wvalid_o,
  output logic [DescWidth-1:0] rx_desc_wdata_o
);

  logic [CountWidth-1:0] count_q;
  logic [CountWidth-1:0] count_d;
  logic                  parity_q;
  logic                  parity_d;
  logic                  overflow_q;
  logic                  overflow_d;
  logic                  byte_accept;
  logic [DescWidth-1:0]  desc;

  assign byte_accept = rx_i.byte_valid & rx_queue_wready_i;

  // Fold in a byte that lands with xfer_end
  always_comb begin
    count_d = count_q;
    if (byte_accept) begin
      count_d = count_q + 1'b1;
    end
    parity_d   = parity_q | (rx_i.byte_valid & rx_i.parity_err);
    overflow_d = overflow_q | (rx_i.byte_valid & ~rx_queue_wready_i);
    desc                   = '0;
    desc[CountWidth-1:0]   = count_d;
    desc[DescParityBit]    = parity_d;
    desc[DescOverflowBit]  = overflow_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_queue_wvalid_o <= 1'b0;
      rx_desc_wvalid_o  <= 1'b0;
      count_q           <= '0;
      parity_q          <= 1'b0;
      overflow_q        <= 1'b0;
    end else begin
      rx_queue_wvalid_o <= byte_accept;
      rx_desc_wvalid_o  <= rx_i.xfer_end;
      if (rx_i.xfer_end) begin
        count_q    <= '0;
        parity_q   <= 1'b0;
        overflow_q <= 1'b0;
      end else begin
        count_q    <= count_d;
        parity_q   <= parity_d;
        overflow_q <= overflow_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_accept) begin
      rx_queue_wdata_o <= rx_i.byte_data;
    end
    if (rx_i.xfer_end) begin
      rx_desc_wdata_o <= desc;
    end
  end

endmodule

`default_nettype wire

// File: i3c_target_top.sv
// Receive-only target; sda_o is open drain and must be ANDed with the bus line outside
`timescale 1ns/100ps
`default_nettype none

module i3c_target_top
  import i3c_target_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 scl_i,
  input  logic                 sda_i,
  input  logic                 target_enable_i,
  input  logic [AddrWidth-1:0] target_addr_i,
  input  logic                 rx_queue_wready_i,
  output logic                 sda_o,
  output logic                 rx_queue_wvalid_o,
  output logic [ByteWidth-1:0] rx_queue_wdata_o,
  output logic                 rx_desc_wvalid_o,
  output logic [DescWidth-1:0] rx_desc_wdata_o,
  output logic                 parity_err_o
);

  bus_event_if bus_events ();
  rx_byte_if   rx_bytes ();

  bus_monitor bus_monitor_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .scl_i  (scl_i),
    .sda_i  (sda_i),
    .bus_o  (bus_events.monitor)
  );

  target_rx_fsm target_rx_fsm_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .target_enable_i (target_enable_i),
    .target_addr_i   (target_addr_i),
    .bus_i           (bus_events.fsm),
    .sda_o           (sda_o),
    .rx_o            (rx_bytes.fsm),
    .parity_err_o    (parity_err_o)
  );

  rx_descriptor_writer rx_descriptor_writer_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rx_i              (rx_bytes.writer),
    .rx_queue_wready_i (rx_queue_wready_i),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .rx_desc_wvalid_o  (rx_desc_wvalid_o),
    .rx_desc_wdata_o   (rx_desc_wdata_o)
  );

endmodule

`default_nettype wire

// File: i3c_target_checker.sv
// Bound into i3c_target_top; the assertions only run when the simulator has assertions enabled
`timescale 1ns/100ps
`default_nettype none

module i3c_target_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic queue_wvalid_i,
  input logic desc_wvalid_i,
  input logic sda_drive_i
);

  // Byte and descriptor strobes never coincide
  queue_desc_apart: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(queue_wvalid_i && desc_wvalid_i))
    else $error("queue and descriptor writes in the same cycle");

  single_queue_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    queue_wvalid_i |=> !queue_wvalid_i)
    else $error("queue write strobe high for two cycles");

  // Line released right out of reset
  sda_released: assert property (@(posedge clk_i) $rose(rst_ni) |-> sda_drive_i)
    else $error("sda_o pulled low after reset release");

endmodule

bind i3c_target_top i3c_target_checker i3c_target_checker_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .queue_wvalid_i (rx_queue_wvalid_o),
  .desc_wvalid_i  (rx_desc_wvalid_o),
  .sda_drive_i    (sda_o)
);

`default_nettype wire

// File: tb_i3c_target.sv
// Target address is 7'h2a; the bus model runs 16 clocks per SCL bit and needs no pull-up model
`timescale 1ns/100ps
`default_nettype none

module tb_i3c_target
  import i3c_target_pkg::*;
();

  typedef struct packed {
    logic [7:0]  header;
    logic [3:0]  nbytes;
    logic [3:0]  perr_idx;
    logic [3:0]  wlow_idx;
    logic        enable;
    logic        rep_start;
    logic        exp_ack;
    logic [31:0] exp_desc;
  } row_t;

  localparam int NumRows = 8;
  localparam int MaxBytes = 4;
  localparam logic [3:0] NoIdx = 4'hf;
  // Header, STOP and drain counted as two more bytes per row
  localparam int TimeoutCycles = NumRows * (MaxBytes + 2) * 9 * 16 + 500;

  // header, bytes, bad T byte, wready low byte, enable, ends in Sr, ACK, descriptor
  localparam row_t Rows [NumRows] = '{
    '{8'h54, 4'd4, NoIdx, NoIdx, 1'b1, 1'b0, 1'b1, 32'h0000_0004},
    '{8'h26, 4'd3, NoIdx, NoIdx, 1'b1, 1'b0, 1'b0, 32'h0000_0000},
    '{8'h55, 4'd2, NoIdx, NoIdx, 1'b1, 1'b0, 1'b0, 32'h0000_0000},
    '{8'h54, 4'd3, 4'd1,  NoIdx, 1'b1, 1'b0, 1'b1, 32'h8000_0003},
    '{8'h54, 4'd4, NoIdx, 4'd2,  1'b1, 1'b0, 1'b1, 32'h4000_0003},
    '{8'h54, 4'd2, NoIdx, NoIdx, 1'b1, 1'b1, 1'b1, 32'h0000_0002},
    '{8'h54, 4'd3, NoIdx, NoIdx, 1'b1, 1'b0, 1'b1, 32'h0000_0003},
    '{8'h54, 4'd2, NoIdx, NoIdx, 1'b0, 1'b0, 1'b0, 32'h0000_0000}
  };

  logic                 clk_i;
  logic                 rst_ni;
  logic                 scl_i;
  logic                 sda_i;
  logic                 tb_sda;
  logic                 target_enable_i;
  logic [AddrWidth-1:0] target_addr_i;
  logic                 rx_queue_wready_i;
  logic                 sda_o;
  logic                 rx_queue_wvalid_o;
  logic [ByteWidth-1:0] rx_queue_wdata_o;
  logic                 rx_desc_wvalid_o;
  logic [DescWidth-1:0] rx_desc_wdata_o;
  logic                 parity_err_o;
  logic [31:0]          lcg_state;
  logic [ByteWidth-1:0] exp_bytes[$];
  logic [DescWidth-1:0] exp_descs[$];
  int mismatch_cnt = 0;
  int other_cnt = 0;
  int parity_seen = 0;
  int parity_exp = 0;
  int cycle_cnt = 0;

  // Open-drain line
  assign sda_i = tb_sda & sda_o;

  i3c_target_top i3c_target_top_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .scl_i             (scl_i),
    .sda_i             (sda_i),
    .target_enable_i   (target_enable_i),
    .target_addr_i     (target_addr_i),
    .rx_queue_wready_i (rx_queue_wready_i),
    .sda_o             (sda_o),
    .rx_queue_wvalid_o (rx_queue_wvalid_o),
    .rx_queue_wdata_o  (rx_queue_wdata_o),
    .rx_desc_wvalid_o  (rx_desc_wvalid_o),
    .rx_desc_wdata_o   (rx_desc_wdata_o),
    .parity_err_o      (parity_err_o)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h, expected %h", name, got, exp);
      mismatch_cnt++;
    end
  endtask

  // Nine bits MSB first, SDA set in the low phase, line sampled mid high phase
  task automatic send_word(input logic [8:0] word, output logic line);
    for (int k = 8; k >= 0; k--) begin
      repeat (4) @(posedge clk_i);
      tb_sda <= word[k];
      repeat (4) @(posedge clk_i);
      scl_i <= 1'b1;
      repeat (4) @(posedge clk_i);
      line = sda_i;
      repeat (4) @(posedge clk_i);
      scl_i <= 1'b0;
    end
  endtask

  // SDA goes to a in the low phase, then to b while SCL is high
  task automatic bus_condition(input logic a, input logic b);
    repeat (4) @(posedge clk_i);
    tb_sda <= a;
    repeat (4) @(posedge clk_i);
    scl_i <= 1'b1;
    repeat (8) @(posedge clk_i);
    tb_sda <= b;
    repeat (8) @(posedge clk_i);
  endtask

  task automatic run_row(input row_t row, input logic after_sr);
    logic [ByteWidth-1:0] data;
    logic                 line;
    target_enable_i <= row.enable;
    if (row.exp_ack) begin
      exp_descs.push_back(row.exp_desc);
    end
    if (!after_sr) begin
      bus_condition(1'b1, 1'b0);
      scl_i <= 1'b0;
    end
    // Ninth bit released so the target can pull it low
    send_word({row.header, 1'b1}, line);
    check_value("ack", !line, row.exp_ack);
    for (int n = 0; n < int'(row.nbytes); n++) begin
      lcg_state = lcg_next(lcg_state);
      data = lcg_state[23:16];
      if (row.exp_ack && n != int'(row.wlow_idx)) begin
        exp_bytes.push_back(data);
      end
      if (row.exp_ack && n == int'(row.perr_idx)) begin
        parity_exp++;
      end
      rx_queue_wready_i <= (n != int'(row.wlow_idx));
      send_word({data, (~^data) ^ (n == int'(row.perr_idx))}, line);
    end
    rx_queue_wready_i <= 1'b1;
    if (row.rep_start) begin
      bus_condition(1'b1, 1'b0);
    end else begin
      bus_condition(1'b0, 1'b1);
    end
    // Descriptor must land before any further header bit
    for (int w = 0; w < 64 && (exp_bytes.size() != 0 || exp_descs.size() != 0); w++) begin
      @(posedge clk_i);
    end
    if (exp_bytes.size() != 0 || exp_descs.size() != 0) begin
      $display("expected queue write or descriptor never arrived");
      other_cnt++;
    end
    if (row.rep_start) begin
      scl_i <= 1'b0;
    end
    check_value("parity_err_o pulses", parity_seen, parity_exp);
  endtask

  always @(posedge clk_i) begin
    if (rx_queue_wvalid_o) begin
      if (exp_bytes.size() == 0) begin
        $display("unexpected write to the RX queue");
        other_cnt++;
      end else begin
        check_value("rx_queue_wdata_o", rx_queue_wdata_o, exp_bytes.pop_front());
      end
    end
    if (rx_desc_wvalid_o) begin
      if (exp_descs.size() == 0) begin
        $display("unexpected RX descriptor write");
        other_cnt++;
      end else begin
        check_value("rx_desc_wdata_o", rx_desc_wdata_o, exp_descs.pop_front());
      end
    end
    if (parity_err_o) begin
      parity_seen++;
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TimeoutCycles) begin
      $display("timeout after %0d cycles", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    logic after_sr;
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    scl_i             = 1'b1;
    tb_sda            = 1'b1;
    target_enable_i   = 1'b1;
    target_addr_i     = 7'h2a;
    rx_queue_wready_i = 1'b1;
    lcg_state         = 32'heb5e_544b;
    after_sr          = 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (4) @(posedge clk_i);
    for (int i = 0; i < NumRows; i++) begin
      run_row(Rows[i], after_sr);
      after_sr = Rows[i].rep_start;
    end
    repeat (16) @(posedge clk_i);
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
i3c_target_pkg.sv
bus_event_if.sv
rx_byte_if.sv
bus_monitor.sv
target_rx_fsm.sv
rx_descriptor_writer.sv
i3c_target_top.sv
i3c_target_checker.sv
tb_i3c_target.sv

// File: run.sh
#!/bin/sh
# Build and run the I3C target testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_i3c_target \
  -f verilog.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
  exit 0
fi
exit 1
